/* beam_trigger_top.f */
+incdir+design
design/beam_trigger_pkg.sv
design/dual_beamform.sv
design/dual_envelope.sv
design/dual_threshold.sv
design/dual_beam.sv
design/beam_trigger_top.sv
bench/beam_trigger_tb.sv

/* bench/beam_trigger_tb.sv */
`timescale 1ns/1ps
`include "beam_trigger_macros.svh"

module beam_trigger_tb import beam_trigger_pkg::*; ();

    localparam int CLK_HALF = 20;      // 40 ns clock
    localparam int N_ROWS   = 10;
    localparam int RND_N    = 200;     // random words in the back-to-back stream

    typedef beam_pair_t [`BT_NUNITS-1:0] unit_words_t;

    logic                    clk_i;
    logic                    arst_n_i;
    unit_words_t             beams_i;
    thresh_casc_t            thresh_i;
    logic [1:0]              thresh_wr_i;
    logic [1:0]              thresh_update_i;
    logic [4*`BT_NUNITS-1:0] trigger_o;

    int          seed;
    int          act_thr [`BT_NUNITS][2][2];   // expected active thresholds, [unit][beam][kind]
    unit_words_t rnd_words [RND_N+8];

    // per row the constant sample value of u0A, u0B, u1A, u1B and the trigger worked out by hand
    // a constant v on all channels forms 8v, squares to 64v^2 and gives an envelope of 512v^2
    int row_val [N_ROWS][4] = '{
        '{-16, -16, -16, -16},   // 131072 against all ones before any update
        '{2, 2, 2, 2},           // 2048 beats only unit 1 (2000 and 1000)
        '{3, 2, 1, -2},          // 4608 > 4000 on u0A and 2048 > 1000 on u1B
        '{0, 3, 3, 0},           // 4608 beats u0B (3000) and u1A (2000)
        '{2, 2, 2, 2},           // new values pending, old ones still decide
        '{-16, -16, -16, -16},   // all kind 0 now at 100000
        '{2, 2, 2, 2},
        '{1, 1, 1, 1},           // 512 beats kind 1 at 200 but not kind 0
        '{-16, -16, -16, -16},
        '{0, 1, 0, 0}
    };
    logic [7:0] row_exp [N_ROWS] = '{
        8'h00, 8'h30, 8'h21, 8'h12, 8'h30, 8'h33, 8'h00, 8'hcc, 8'hff, 8'h08
    };

    beam_trigger_top dut_i (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .beams_i         (beams_i),
        .thresh_i        (thresh_i),
        .thresh_wr_i     (thresh_wr_i),
        .thresh_update_i (thresh_update_i),
        .trigger_o       (trigger_o)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    // a stopped clock ends the run instead of hanging it
    task automatic next_fall();
        bit got;
        got = 0;
        fork
            begin
                @(negedge clk_i);
                got = 1;
            end
            begin
                #(4 * CLK_HALF);
            end
        join_any
        disable fork;
        if (!got) begin
            $display("no falling clock edge arrived within two clock periods");
            $display("TEST FAILED");
            $fatal(1, "clock timeout");
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic beam_word_t const_word(input int v);
        beam_word_t w;
        for (int c = 0; c < `BT_NCHAN; c++) begin
            for (int s = 0; s < `BT_NSAMP; s++) begin
                w[c][s] = sample_t'(v);
            end
        end
        return w;
    endfunction

    // sum of squared formed samples base..base+3 of one word
    function automatic int half_power(input beam_word_t w, input int base);
        int acc;
        int f;
        acc = 0;
        for (int s = base; s < base + `BT_NSAMP / 2; s++) begin
            f = 0;
            for (int c = 0; c < `BT_NCHAN; c++) begin
                f += int'(w[c][s]);
            end
            acc += f * f;
        end
        return acc;
    endfunction

    function automatic int envelope_model(input beam_word_t prev, input beam_word_t cur);
        int w0;
        int w1;
        w0 = half_power(prev, 4) + half_power(cur, 0);   // straddles the clock boundary
        w1 = half_power(cur, 0) + half_power(cur, 4);
        return (w0 > w1) ? w0 : w1;
    endfunction

    function automatic logic [7:0] trigger_model(input unit_words_t prev, input unit_words_t cur);
        logic [7:0] t;
        int         env;
        t = '0;
        for (int u = 0; u < `BT_NUNITS; u++) begin
            for (int b = 0; b < 2; b++) begin
                env = (b == 0) ? envelope_model(prev[u].beam_a, cur[u].beam_a)
                               : envelope_model(prev[u].beam_b, cur[u].beam_b);
                for (int k = 0; k < 2; k++) begin
                    t[4*u + 2*k + b] = env > act_thr[u][b][k];
                end
            end
        end
        return t;
    endfunction

    task automatic write_thresh(input int kind, input int val);
        if (kind == 0) thresh_i.kind0 = thresh_t'(val);
        else           thresh_i.kind1 = thresh_t'(val);
        thresh_wr_i[kind] = 1'b1;
        next_fall();
        thresh_wr_i = '0;
    endtask

    task automatic update_thresh(input int kind);
        thresh_update_i[kind] = 1'b1;
        next_fall();
        thresh_update_i = '0;
    endtask

    // each row is held long enough that words t and t-1 both belong to it
    task automatic run_rows(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            beams_i[0].beam_a = const_word(row_val[r][0]);
            beams_i[0].beam_b = const_word(row_val[r][1]);
            beams_i[1].beam_a = const_word(row_val[r][2]);
            beams_i[1].beam_b = const_word(row_val[r][3]);
            repeat (7) next_fall();
            check_value($sformatf("trigger for row %0d", r), trigger_o, row_exp[r]);
        end
    endtask

    task automatic set_kind0_ramp();
        for (int i = 1; i <= 4; i++) begin
            write_thresh(0, 1000 * i);   // first value written ends in unit 1 beam B
        end
        update_thresh(0);
        act_thr[0][0][0] = 4000;
        act_thr[0][1][0] = 3000;
        act_thr[1][0][0] = 2000;
        act_thr[1][1][0] = 1000;
    endtask

    initial begin
        unit_words_t prev;
        sample_t     smp;
        int          sh;
        clk_i           = 1'b0;
        arst_n_i        = 1'b0;
        beams_i         = '0;
        thresh_i        = '0;
        thresh_wr_i     = '0;
        thresh_update_i = '0;
        seed            = 32'he4f2;
        for (int u = 0; u < `BT_NUNITS; u++) begin
            for (int b = 0; b < 2; b++) begin
                act_thr[u][b][0] = 262143;
                act_thr[u][b][1] = 262143;
            end
        end
        repeat (10) next_fall();
        arst_n_i = 1'b1;
        next_fall();

        run_rows(0, 0);      // full scale with reset thresholds stays quiet
        set_kind0_ramp();
        run_rows(1, 3);      // shift order across both units
        for (int i = 0; i < 4; i++) begin
            write_thresh(0, 100000);
        end
        run_rows(4, 4);      // pending only, nothing changes yet
        update_thresh(0);
        run_rows(5, 6);
        for (int i = 0; i < 4; i++) begin
            write_thresh(1, 200);
        end
        update_thresh(1);
        for (int u = 0; u < `BT_NUNITS; u++) begin
            for (int b = 0; b < 2; b++) begin
                act_thr[u][b][1] = 200;   // every kind 1 register got the same value
            end
        end
        run_rows(7, 9);      // kind 1 is lower, only its bits fire

        // one large sample in the upper half counts in W1 now and in W0 a clock later
        beams_i = '0;
        repeat (7) next_fall();
        beams_i[0].beam_a[0][5] = sample_t'(-16);   // square 256 against kind 1 at 200
        for (int c = 1; c <= 8; c++) begin
            next_fall();
            beams_i = '0;
            if (c >= 4) begin
                check_value($sformatf("window pulse cycle %0d", c), trigger_o,
                            (c == 5 || c == 6) ? 8'h04 : 8'h00);
            end
        end

        set_kind0_ramp();
        for (int i = 0; i < RND_N + 8; i++) begin
            rnd_words[i] = '0;
            if (i < RND_N) begin
                for (int u = 0; u < `BT_NUNITS; u++) begin
                    sh = $random(seed) & 3;   // vary the level so thresholds are crossed both ways
                    for (int c = 0; c < `BT_NCHAN; c++) begin
                        for (int s = 0; s < `BT_NSAMP; s++) begin
                            smp = sample_t'($random(seed));
                            rnd_words[i][u].beam_a[c][s] = smp >>> sh;
                            smp = sample_t'($random(seed));
                            rnd_words[i][u].beam_b[c][s] = smp >>> sh;
                        end
                    end
                end
            end
        end
        beams_i = '0;
        repeat (7) next_fall();
        // word j is sampled on the next rising edge, its trigger shows up five falls later
        for (int j = 0; j < RND_N + 8; j++) begin
            if (j >= 5) begin
                prev = (j >= 6) ? rnd_words[j-6] : '0;
                check_value($sformatf("random word %0d", j - 5), trigger_o,
                            trigger_model(prev, rnd_words[j-5]));
            end
            beams_i = rnd_words[j];
            next_fall();
        end

        $display("TEST OK");
        $finish;
    end

endmodule

/* design/beam_trigger_macros.svh */
`ifndef BEAM_TRIGGER_MACROS_SVH
`define BEAM_TRIGGER_MACROS_SVH

// width of one raw channel sample, signed
`define BT_NBITS 5

// samples delivered per clock on every channel
`define BT_NSAMP 8

// channels summed into one beam
`define BT_NCHAN 8

// thresholds and envelopes share this width so the compare needs no padding
`define BT_THBITS 18

// beam units chained on the threshold cascade
`define BT_NUNITS 2

`endif

/* design/beam_trigger_pkg.sv */
`include "beam_trigger_macros.svh"

package beam_trigger_pkg;

    // 8 signed channels of 5 bits sum to at most -128..120, so 3 growth bits
    localparam int FORM_BITS = `BT_NBITS + 3;
    localparam int SQ_BITS   = 2 * FORM_BITS - 1;      // (-128)^2 = 16384 fits in 15 bits
    localparam int HALF_BITS = SQ_BITS + 2;            // sum of four squares
    localparam int SQ_MAX    = 1 << (2 * (FORM_BITS - 1));
    localparam int ENV_MAX   = `BT_NSAMP * SQ_MAX;     // full 8-sample boxcar at full scale

    typedef logic signed [`BT_NBITS-1:0] sample_t;
    typedef sample_t [`BT_NCHAN-1:0][`BT_NSAMP-1:0] beam_word_t; // indexed [chan][samp]

    typedef struct packed {
        beam_word_t beam_a;
        beam_word_t beam_b;
    } beam_pair_t;

    typedef logic signed [FORM_BITS-1:0] form_t;      // one formed beam sample
    typedef form_t [`BT_NSAMP-1:0] form_word_t;

    typedef logic [SQ_BITS-1:0] square_t;
    typedef square_t [`BT_NSAMP-1:0] square_word_t;

    typedef struct packed {
        square_word_t sq_a;
        square_word_t sq_b;
    } square_pair_t;

    typedef logic [HALF_BITS-1:0] half_t;
    typedef logic [`BT_THBITS-1:0] env_t;

    typedef struct packed {
        env_t env_a;
        env_t env_b;
    } env_pair_t;

    typedef logic [`BT_THBITS-1:0] thresh_t;

    // kind 0 sits in the low bits so bit k of the strobes lines up with field k
    typedef struct packed {
        thresh_t kind1;
        thresh_t kind0;
    } thresh_casc_t;

endpackage

/* design/beam_trigger_top.sv */
`timescale 1ns/1ps
`include "beam_trigger_macros.svh"

module beam_trigger_top import beam_trigger_pkg::*; (
    input  logic                       clk_i,
    input  logic                       arst_n_i,
    input  beam_pair_t [`BT_NUNITS-1:0] beams_i,          // one beam pair per unit
    input  thresh_casc_t               thresh_i,
    input  logic [1:0]                 thresh_wr_i,       // bit k shifts kind k
    input  logic [1:0]                 thresh_update_i,   // bit k loads kind k
    output logic [4*`BT_NUNITS-1:0]    trigger_o
);

    // casc[u] feeds unit u; the entry after the last unit goes nowhere
    thresh_casc_t casc [`BT_NUNITS+1];

    assign casc[0] = thresh_i;

    // thresholds enter at unit 0 and walk towards the last unit on each write,
    // so the first value written ends up furthest down the chain
    for (genvar u = 0; u < `BT_NUNITS; u++) begin : g_unit
        dual_beam u_beam (
            .clk_i           (clk_i),
            .arst_n_i        (arst_n_i),
            .beams_i         (beams_i[u]),
            .thresh_casc_i   (casc[u]),
            .thresh_wr_i     (thresh_wr_i),
            .thresh_update_i (thresh_update_i),
            .thresh_casc_o   (casc[u+1]),
            .trigger_o       (trigger_o[4*u +: 4])
        );
    end

endmodule

/* design/dual_beam.sv */
`timescale 1ns/1ps

module dual_beam import beam_trigger_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  beam_pair_t   beams_i,
    input  thresh_casc_t thresh_casc_i,   // thresh_i for the first unit, else previous unit
    input  logic [1:0]   thresh_wr_i,
    input  logic [1:0]   thresh_update_i,
    output thresh_casc_t thresh_casc_o,
    output logic [3:0]   trigger_o
);

    square_pair_t squares;   // two cycles after the input word
    env_pair_t    env;       // two more cycles, then one to the trigger

    dual_beamform u_beamform (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .beams_i   (beams_i),
        .squares_o (squares)
    );

    dual_envelope u_envelope (
        .clk_i     (clk_i),
        .arst_n_i  (arst_n_i),
        .squares_i (squares),
        .env_o     (env)
    );

    // the envelope is already threshold width, so it goes straight in
    dual_threshold u_threshold (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .thresh_casc_i   (thresh_casc_i),
        .thresh_wr_i     (thresh_wr_i),
        .thresh_update_i (thresh_update_i),
        .env_i           (env),
        .thresh_casc_o   (thresh_casc_o),
        .trigger_o       (trigger_o)
    );

endmodule

/* design/dual_beamform.sv */
`timescale 1ns/1ps
`include "beam_trigger_macros.svh"

module dual_beamform import beam_trigger_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  beam_pair_t   beams_i,
    output square_pair_t squares_o
);

    form_word_t form_a_q;   // formed beam A, one entry per sample index
    form_word_t form_b_q;   // formed beam B

    // adds all channels that share a sample index
    // each sample is sign extended to the formed width first, so the sum cannot wrap
    function automatic form_word_t form_beam(input beam_word_t word);
        form_word_t res;
        for (int s = 0; s < `BT_NSAMP; s++) begin
            res[s] = '0;
            for (int c = 0; c < `BT_NCHAN; c++) begin
                res[s] = res[s] + form_t'($signed(word[c][s]));
            end
        end
        return res;
    endfunction

    function automatic square_word_t square_beam(input form_word_t f);
        square_word_t res;
        logic signed [2*FORM_BITS-1:0] prod;
        for (int s = 0; s < `BT_NSAMP; s++) begin
            prod   = $signed(f[s]) * $signed(f[s]);   // always positive, top bit drops
            res[s] = prod[SQ_BITS-1:0];
        end
        return res;
    endfunction

    // the largest square comes from -128 and is exactly SQ_MAX
    function automatic logic squares_in_range(input square_pair_t sq);
        logic ok;
        ok = 1'b1;
        for (int s = 0; s < `BT_NSAMP; s++) begin
            ok &= (int'(sq.sq_a[s]) <= SQ_MAX) && (int'(sq.sq_b[s]) <= SQ_MAX);
        end
        return ok;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            form_a_q  <= '0;
            form_b_q  <= '0;
            squares_o <= '0;
        end else begin
            form_a_q       <= form_beam(beams_i.beam_a);  // stage 1, sum register
            form_b_q       <= form_beam(beams_i.beam_b);
            squares_o.sq_a <= square_beam(form_a_q);      // stage 2, square register
            squares_o.sq_b <= square_beam(form_b_q);
        end
    end

    a_square_range : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        squares_in_range(squares_o));

endmodule

/* design/dual_envelope.sv */
`timescale 1ns/1ps
`include "beam_trigger_macros.svh"

module dual_envelope import beam_trigger_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  square_pair_t squares_i,
    output env_pair_t    env_o
);

    // beam A is index 0 and beam B is index 1, so both beams run through the same loops
    square_word_t sq [2];
    half_t        lo_q      [2];   // squares 0..3 of the current clock
    half_t        hi_q      [2];   // squares 4..7 of the current clock
    half_t        hi_prev_q [2];   // squares 4..7 of the clock before
    env_t         win0      [2];   // window straddling the clock boundary
    env_t         win1      [2];   // window aligned to the clock
    env_t         env_q     [2];

    assign sq[0] = squares_i.sq_a;
    assign sq[1] = squares_i.sq_b;

    // four consecutive squares starting at base
    function automatic half_t half_sum(input square_word_t w, input int base);
        half_t acc;
        acc = '0;
        for (int i = 0; i < `BT_NSAMP / 2; i++) begin
            acc = acc + half_t'(w[base+i]);
        end
        return acc;
    endfunction

    // stage 1 splits each clock into two half windows
    // the old upper half is kept so the straddling window can be built
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int b = 0; b < 2; b++) begin
                lo_q[b]      <= '0;
                hi_q[b]      <= '0;
                hi_prev_q[b] <= '0;   // the clock before the first word counts as silence
            end
        end else begin
            for (int b = 0; b < 2; b++) begin
                lo_q[b]      <= half_sum(sq[b], 0);
                hi_q[b]      <= half_sum(sq[b], `BT_NSAMP / 2);
                hi_prev_q[b] <= hi_q[b];
            end
        end
    end

    // decimating the 8-sample boxcar by 4 leaves two windows per clock
    always_comb begin
        for (int b = 0; b < 2; b++) begin
            win1[b] = env_t'(lo_q[b]) + env_t'(hi_q[b]);
            win0[b] = env_t'(hi_prev_q[b]) + env_t'(lo_q[b]);
        end
    end

    // stage 2 keeps only the larger window, which is all the trigger cares about
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int b = 0; b < 2; b++) begin
                env_q[b] <= '0;
            end
        end else begin
            for (int b = 0; b < 2; b++) begin
                env_q[b] <= (win0[b] > win1[b]) ? win0[b] : win1[b];
            end
        end
    end

    assign env_o.env_a = env_q[0];
    assign env_o.env_b = env_q[1];

    // holds only while every square upstream stays at or below full scale
    a_env_range : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (int'(env_o.env_a) <= ENV_MAX) && (int'(env_o.env_b) <= ENV_MAX));

endmodule

/* design/dual_threshold.sv */
`timescale 1ns/1ps

module dual_threshold import beam_trigger_pkg::*; (
    input  logic         clk_i,
    input  logic         arst_n_i,
    input  thresh_casc_t thresh_casc_i,
    input  logic [1:0]   thresh_wr_i,
    input  logic [1:0]   thresh_update_i,
    input  env_pair_t    env_i,
    output thresh_casc_t thresh_casc_o,
    output logic [3:0]   trigger_o
);

    // all arrays below are indexed by threshold kind
    thresh_t casc_in  [2];
    thresh_t pend_a_q [2];   // first stop in this unit's part of the shift chain
    thresh_t pend_b_q [2];   // second stop, also what the next unit sees
    thresh_t act_a_q  [2];   // thresholds the compare actually uses
    thresh_t act_b_q  [2];

    assign casc_in[0] = thresh_casc_i.kind0;
    assign casc_in[1] = thresh_casc_i.kind1;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int k = 0; k < 2; k++) begin
                pend_a_q[k] <= '0;
                pend_b_q[k] <= '0;
                act_a_q[k]  <= '1;   // nothing can exceed all ones
                act_b_q[k]  <= '1;
            end
        end else begin
            for (int k = 0; k < 2; k++) begin
                // a write shifts the chain by one place in every unit on the same edge
                if (thresh_wr_i[k]) begin
                    pend_a_q[k] <= casc_in[k];
                    pend_b_q[k] <= pend_a_q[k];
                end
                // the update sees the pending values from before any write on this edge
                if (thresh_update_i[k]) begin
                    act_a_q[k] <= pend_a_q[k];
                    act_b_q[k] <= pend_b_q[k];
                end
            end
        end
    end

    assign thresh_casc_o.kind0 = pend_b_q[0];
    assign thresh_casc_o.kind1 = pend_b_q[1];

    // bit order is A/kind0, B/kind0, A/kind1, B/kind1
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            trigger_o <= '0;
        end else begin
            trigger_o[0] <= env_i.env_a > act_a_q[0];
            trigger_o[1] <= env_i.env_b > act_b_q[0];
            trigger_o[2] <= env_i.env_a > act_a_q[1];   // strictly greater, equal does not fire
            trigger_o[3] <= env_i.env_b > act_b_q[1];
        end
    end

    // an unknown here would come from an undriven threshold or envelope input
    a_trigger_known : assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(trigger_o));

endmodule

/* run_sim.sh */
#!/bin/bash
# builds the beam trigger testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f beam_trigger_top.f \
    --top-module beam_trigger_tb \
    > build.log 2>&1 \
    && ./obj_dir/Vbeam_trigger_tb > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "TEST OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
